// File: dw_pkg.sv
`default_nettype none

package dw_pkg;

  localparam int WORD_WIDTH     = 16;
  localparam int ROWS           = 2;
  localparam int COLS           = 12;
  localparam int KW_MAX         = 5;
  localparam int SW_MAX         = 2;
  localparam int MEMBERS_MAX    = 4;
  localparam int BITS_KW2       = 2;
  localparam int BITS_SW        = 1;
  localparam int BITS_MEMBERS   = 2;
  localparam int BITS_OUT_SHIFT = 3;

  localparam logic [3:0] ADDR_KERNEL  = 4'h0;
  localparam logic [3:0] ADDR_STRIDE  = 4'h4;
  localparam logic [3:0] ADDR_MEMBERS = 4'h8;

  typedef logic [ROWS-1:0][WORD_WIDTH-1:0] column_t;
  typedef column_t [COLS-1:0] bank_t;

  typedef struct packed {
    logic [BITS_KW2-1:0]     kw2;       // Kernel = 2*kw2 + 1
    logic [BITS_SW-1:0]      sw_1;      // Stride - 1
    logic [BITS_MEMBERS-1:0] members_1; // Views per beat - 1
  } dw_cfg_t;

  localparam dw_cfg_t CFG_RESET = '{kw2: 2'd1, sw_1: 1'b0, members_1: 2'd0};

  // One shifted view as it travels from stage A to stage B
  typedef struct packed {
    bank_t   bank;
    dw_cfg_t cfg;
  } view_t;

  // Output beat held in the skid buffer
  typedef struct packed {
    logic    last;
    column_t col;
  } out_t;

  localparam int VIEW_WIDTH = $bits(view_t);
  localparam int COL_WIDTH  = $bits(column_t);

  // Group length j = k + s - 1 must divide the bank
  function automatic logic cfg_legal(input logic [BITS_KW2-1:0] kw2,
                                     input logic [BITS_SW-1:0]  sw_1);
    int k;
    int j;
    k = 2 * kw2 + 1;
    j = k + sw_1;
    return (k == 3 || k == 5) && (k <= KW_MAX) && (sw_1 < SW_MAX) && (COLS % j == 0);
  endfunction

endpackage

`default_nettype wire

// File: dw_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Valid/ready stream with a packet end flag
interface dw_stream_if #(
  parameter int WIDTH = 32
);

  logic             valid;
  logic             ready;
  logic             last;
  logic [WIDTH-1:0] data;

  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// File: dw_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dw_cfg_regs (
  input  wire             aclk,
  input  wire             rst,
  input  wire             psel,
  input  wire             penable,
  input  wire             pwrite,
  input  wire  [3:0]      paddr,
  input  wire  [31:0]     pwdata,
  output logic [31:0]     prdata,
  output logic            pready,
  output logic            pslverr,
  output dw_pkg::dw_cfg_t cfg
);

  import dw_pkg::*;

  logic        access;
  logic        wr_err;
  logic [31:0] rdata;

  assign access = psel & penable;
  assign pready = 1'b1; // Zero wait states

  // Kernel and stride are judged against the other register's current value
  always_comb begin
    wr_err = 1'b0;
    case (paddr)
      ADDR_KERNEL:
        wr_err = (pwdata[31:BITS_KW2] != '0) || !cfg_legal(pwdata[BITS_KW2-1:0], cfg.sw_1);
      ADDR_STRIDE:
        wr_err = (pwdata[31:BITS_SW] != '0) || !cfg_legal(cfg.kw2, pwdata[BITS_SW-1:0]);
      ADDR_MEMBERS:
        wr_err = (pwdata >= MEMBERS_MAX);
      default:
        wr_err = 1'b1; // Unmapped offset
    endcase
  end

  assign pslverr = access & pwrite & wr_err;

  always_ff @(posedge aclk) begin
    if (rst) begin
      cfg <= CFG_RESET;
    end else if (access && pwrite && !wr_err) begin
      case (paddr)
        ADDR_KERNEL:  cfg.kw2       <= pwdata[BITS_KW2-1:0];
        ADDR_STRIDE:  cfg.sw_1      <= pwdata[BITS_SW-1:0];
        ADDR_MEMBERS: cfg.members_1 <= pwdata[BITS_MEMBERS-1:0];
        default:      cfg           <= cfg;
      endcase
    end
  end

  always_comb begin
    case (paddr)
      ADDR_KERNEL:  rdata = 32'(cfg.kw2);
      ADDR_STRIDE:  rdata = 32'(cfg.sw_1);
      ADDR_MEMBERS: rdata = 32'(cfg.members_1);
      default:      rdata = '0;
    endcase
  end

  // Captured in setup so it is ready for the access phase
  always_ff @(posedge aclk) begin
    if (rst) begin
      prdata <= '0;
    end else if (psel && !penable && !pwrite) begin
      prdata <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: dw_column_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module dw_column_shifter (
  input  wire             aclk,
  input  wire             rst,
  input  wire dw_pkg::dw_cfg_t cfg,
  input  wire             s_valid,
  output logic            s_ready,
  input  wire dw_pkg::bank_t   s_data,
  input  wire             s_last,
  dw_stream_if.source     a_out
);

  import dw_pkg::*;

  logic [BITS_MEMBERS-1:0] count;
  logic                    count_last;
  logic                    valid_q;
  logic                    last_q;
  logic                    s_hs;
  logic                    a_hs;
  bank_t                   bank_q;
  dw_cfg_t                 cfg_q;
  view_t                   view;

  assign count_last = (count == '0);
  assign a_hs       = valid_q & a_out.ready;
  assign s_ready    = ~valid_q | (a_out.ready & count_last); // Idle or final view leaving
  assign s_hs       = s_valid & s_ready;

  ////////////////////
  // Member counter
  ////////////////////

  always_ff @(posedge aclk) begin
    if (rst) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      count   <= '0;
    end else if (s_hs) begin
      valid_q <= 1'b1;
      last_q  <= s_last;
      count   <= cfg.members_1;
    end else if (a_hs) begin
      if (count_last) begin
        valid_q <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////
  // Bank shift register
  ////////////////////

  always_ff @(posedge aclk) begin
    if (s_hs) begin
      bank_q <= s_data;
      cfg_q  <= cfg; // Config follows the beat
    end else if (a_hs && !count_last) begin
      bank_q <= {bank_q[COLS-2:0], column_t'('0)}; // One column up, zero fill
    end
  end

  assign view.bank = bank_q;
  assign view.cfg  = cfg_q;

  assign a_out.valid = valid_q;
  assign a_out.last  = last_q & count_last;
  assign a_out.data  = view;

endmodule

`default_nettype wire

// File: dw_column_select.sv
`timescale 1ns/1ps
`default_nettype none

module dw_column_select (
  input wire          aclk,
  input wire          rst,
  dw_stream_if.sink   a_in,
  dw_stream_if.source b_out
);

  import dw_pkg::*;

  localparam int SEL_LEN = COLS / 3; // Longest selection, kernel 3 stride 1

  view_t                     view;
  column_t [SEL_LEN-1:0]     sel_tab [2**BITS_KW2][2**BITS_SW];
  logic [BITS_OUT_SHIFT-1:0] cnt_tab [2**BITS_KW2][2**BITS_SW];
  column_t [SEL_LEN-1:0]     col_q;
  logic [BITS_OUT_SHIFT-1:0] count;
  logic                      count_last;
  logic                      valid_q;
  logic                      last_q;
  logic                      a_hs;
  logic                      b_hs;

  assign view = a_in.data;

  ////////////////////
  // Selection table
  ////////////////////

  for (genvar kw2 = 0; kw2 < 2**BITS_KW2; kw2++) begin : g_kw2
    for (genvar sw_1 = 0; sw_1 < 2**BITS_SW; sw_1++) begin : g_sw
      localparam int J     = 2 * kw2 + 1 + sw_1;
      localparam bit LEGAL = cfg_legal(BITS_KW2'(kw2), BITS_SW'(sw_1));
      localparam int G     = LEGAL ? COLS / J : 1;

      assign cnt_tab[kw2][sw_1] = BITS_OUT_SHIFT'(G - 1);

      for (genvar i = 0; i < SEL_LEN; i++) begin : g_col
        if (LEGAL && i < G) begin : g_sel
          assign sel_tab[kw2][sw_1][i] = view.bank[i*J + J - 1]; // Last column of group i
        end else begin : g_zero
          assign sel_tab[kw2][sw_1][i] = '0;
        end
      end
    end
  end

  ////////////////////
  // Output serializer
  ////////////////////

  assign count_last = (count == '0);
  assign a_in.ready = ~valid_q | (b_out.ready & count_last);
  assign a_hs       = a_in.valid & a_in.ready;
  assign b_hs       = valid_q & b_out.ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      count   <= '0;
    end else if (a_hs) begin
      valid_q <= 1'b1;
      last_q  <= a_in.last;
      count   <= cnt_tab[view.cfg.kw2][view.cfg.sw_1];
    end else if (b_hs) begin
      if (count_last) begin
        valid_q <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (a_hs) begin
      col_q <= sel_tab[view.cfg.kw2][view.cfg.sw_1];
    end else if (b_hs && !count_last) begin
      col_q <= {column_t'('0), col_q[SEL_LEN-1:1]}; // Next group to the front
    end
  end

  assign b_out.valid = valid_q;
  assign b_out.last  = last_q & count_last;
  assign b_out.data  = col_q[0];

endmodule

`default_nettype wire

// File: skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  wire           aclk,
  input  wire           rst,
  input  wire           s_valid,
  output logic          s_ready,
  input  wire payload_t s_data,
  output logic          m_valid,
  input  wire           m_ready,
  output payload_t      m_data
);

  logic     main_valid;
  logic     skid_valid;
  logic     main_free;
  logic     s_hs;
  payload_t main_q;
  payload_t skid_q;

  assign main_free = ~main_valid | m_ready;
  assign s_ready   = ~skid_valid; // Flop output only
  assign s_hs      = s_valid & s_ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;   // Drain the skid entry first
      end else begin
        main_valid <= s_hs;
      end
    end else if (s_hs) begin
      skid_valid <= 1'b1;     // Main stalled, park the new item
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      main_q <= skid_valid ? skid_q : s_data;
    end
    if (!main_free && s_hs) begin
      skid_q <= s_data;
    end
  end

  assign m_valid = main_valid;
  assign m_data  = main_q;

endmodule

`default_nettype wire

// File: dw_shift_top.sv
`timescale 1ns/1ps
`default_nettype none

module dw_shift_top (
  input  wire                    aclk,
  input  wire                    rst,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire  [3:0]             paddr,
  input  wire  [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  wire                    s_valid,
  output logic                   s_ready,
  input  wire dw_pkg::bank_t     s_data,
  input  wire                    s_last,
  output logic                   m_valid,
  input  wire                    m_ready,
  output dw_pkg::column_t        m_data,
  output logic                   m_last
);

  import dw_pkg::*;

  dw_cfg_t cfg;
  out_t    b_payload;
  out_t    m_payload;

  dw_stream_if #(.WIDTH(VIEW_WIDTH)) a_if ();
  dw_stream_if #(.WIDTH(COL_WIDTH))  b_if ();

  dw_cfg_regs u_regs (
    .aclk    (aclk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg)
  );

  dw_column_shifter u_shifter (
    .aclk    (aclk),
    .rst     (rst),
    .cfg     (cfg),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_last  (s_last),
    .a_out   (a_if.source)
  );

  dw_column_select u_select (
    .aclk  (aclk),
    .rst   (rst),
    .a_in  (a_if.sink),
    .b_out (b_if.source)
  );

  assign b_payload.last = b_if.last;
  assign b_payload.col  = b_if.data;

  skid_buffer #(
    .payload_t (out_t)
  ) u_out_buf (
    .aclk    (aclk),
    .rst     (rst),
    .s_valid (b_if.valid),
    .s_ready (b_if.ready),
    .s_data  (b_payload),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_payload)
  );

  assign m_data = m_payload.col;
  assign m_last = m_payload.last;

endmodule

`default_nettype wire

// File: dw_shift_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dw_shift_checker (
  input wire                  aclk,
  input wire                  rst,
  input wire                  pslverr,
  input wire dw_pkg::dw_cfg_t cfg,
  input wire                  m_valid,
  input wire                  m_ready,
  input wire dw_pkg::column_t m_data,
  input wire                  m_last
);

  // Stalled output holds its payload
  a_stall_stable: assert property (@(posedge aclk) disable iff (rst)
    (m_valid && !m_ready) |=> ($stable(m_data) && $stable(m_last)))
    else $error("m_data or m_last changed while stalled");

  a_valid_hold: assert property (@(posedge aclk) disable iff (rst)
    (m_valid && !m_ready) |=> m_valid)
    else $error("m_valid dropped without a transfer");

  a_slverr_keeps_cfg: assert property (@(posedge aclk) disable iff (rst)
    pslverr |=> $stable(cfg)) // Rejected write leaves the old value
    else $error("configuration changed on a rejected write");

  a_valid_known: assert property (@(posedge aclk) disable iff (rst)
    !$isunknown(m_valid))
    else $error("m_valid is unknown");

endmodule

bind dw_shift_top dw_shift_checker u_checker (
  .aclk    (aclk),
  .rst     (rst),
  .pslverr (pslverr),
  .cfg     (cfg),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data),
  .m_last  (m_last)
);

`default_nettype wire

// File: tb_dw_shift.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dw_shift;

  import dw_pkg::*;

  localparam int NUM_BEATS      = 200;
  localparam int MAX_OUTS       = 16;                           // Four views of four columns
  localparam int TIMEOUT_CYCLES = NUM_BEATS * MAX_OUTS * 25 / 4; // Random stalls plus margin
  localparam int QUIET_CYCLES   = 16;

  logic        aclk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        s_valid;
  logic        s_ready;
  bank_t       s_data;
  logic        s_last;
  logic        m_valid;
  logic        m_ready;
  column_t     m_data;
  logic        m_last;

  integer      seed       = 32'hf0d16692;
  integer      ready_seed = 32'hf0d16692 ^ 32'h5555_5555; // Separate stream for m_ready
  int          cycles      = 0;
  int          beats_sent  = 0;
  logic [1:0]  cur_kw2;
  logic        cur_sw_1;
  logic [1:0]  cur_members_1;
  logic [31:0] rd;
  column_t     exp_col [$];
  logic        exp_last [$];

  dw_shift_top uut (
    .aclk    (aclk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_last  (s_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  ////////////////////
  // APB access
  ////////////////////

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge aclk);
    #1;
    penable = 1'b1;
    @(negedge aclk); // Access phase
    check_value("pslverr", pslverr, exp_err);
    check_value("pready", pready, 1'b1);
    @(posedge aclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge aclk);
    #1;
    penable = 1'b1;
    @(negedge aclk);
    data = prdata;
    @(posedge aclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Stride 2 is legal with either kernel, so it goes in first
  task automatic apply_cfg(input int kw2, input int sw_1, input int members_1);
    write_reg(ADDR_STRIDE, 32'd1, 1'b0);
    write_reg(ADDR_KERNEL, 32'(kw2), 1'b0);
    write_reg(ADDR_STRIDE, 32'(sw_1), 1'b0);
    write_reg(ADDR_MEMBERS, 32'(members_1), 1'b0);
    cur_kw2       = 2'(kw2);
    cur_sw_1      = 1'(sw_1);
    cur_members_1 = 2'(members_1);
    read_reg(ADDR_KERNEL, rd);
    check_value("prdata kernel", rd, 32'(kw2));
    read_reg(ADDR_STRIDE, rd);
    check_value("prdata stride", rd, 32'(sw_1));
    read_reg(ADDR_MEMBERS, rd);
    check_value("prdata members", rd, 32'(members_1));
  endtask

  ////////////////////
  // Stream and model
  ////////////////////

  task automatic model_beat(input bank_t bank, input logic last);
    int      k;
    int      j;
    int      g;
    int      m;
    int      c;
    int      v;
    int      i;
    column_t col;
    k = 2 * cur_kw2 + 1;
    j = k + cur_sw_1;      // Group length
    g = COLS / j;
    m = cur_members_1 + 1;
    for (v = 0; v < m; v++) begin
      for (i = 0; i < g; i++) begin
        c   = i * j + j - 1;
        col = (c >= v) ? bank[c - v] : '0; // View v moves column c-v up to c
        exp_col.push_back(col);
        exp_last.push_back(last && v == m - 1 && i == g - 1);
      end
    end
  endtask

  task automatic send_burst(input int n);
    int   b;
    int   c;
    int   r;
    int   gap;
    logic taken;
    for (b = 0; b < n; b++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge aclk);
        #1;
      end
      for (c = 0; c < COLS; c++) begin
        for (r = 0; r < ROWS; r++) begin
          s_data[c][r] = 16'($random(seed));
        end
      end
      s_last  = (beats_sent % 4 == 3);
      s_valid = 1'b1;
      taken   = 1'b0;
      while (!taken) begin
        @(negedge aclk);
        taken = s_ready;
        @(posedge aclk);
        #1;
      end
      beats_sent++;
      s_valid = 1'b0;
      s_last  = 1'b0;
    end
  endtask

  task automatic wait_idle();
    while (exp_col.size() != 0) begin
      @(posedge aclk);
      #1;
    end
  endtask

  // Random back-pressure, ready three cycles in four
  initial begin
    m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      m_ready = ($random(ready_seed) & 3) != 0;
    end
  end

  always @(negedge aclk) begin
    if (!rst) begin
      if (s_valid && s_ready) begin
        model_beat(s_data, s_last);
      end
      if (m_valid && m_ready) begin
        if (exp_col.size() == 0) begin
          $display("Output transfer arrived with no expected column left in the model");
          $display("TEST FAIL");
          $fatal(1);
        end else begin
          check_value("m_data", m_data, exp_col.pop_front());
          check_value("m_last", m_last, exp_last.pop_front());
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the output stream did not drain", cycles);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  initial begin
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    s_valid = 1'b0;
    s_data  = '0;
    s_last  = 1'b0;
    repeat (8) @(posedge aclk);
    #1;
    rst = 1'b0;

    check_value("m_valid", m_valid, 1'b0);
    read_reg(ADDR_KERNEL, rd);
    check_value("prdata kernel", rd, 32'd1);
    read_reg(ADDR_STRIDE, rd);
    check_value("prdata stride", rd, 32'd0);
    read_reg(ADDR_MEMBERS, rd);
    check_value("prdata members", rd, 32'd0);

    write_reg(ADDR_MEMBERS, 32'd4, 1'b1); // Five members is out of range
    read_reg(ADDR_MEMBERS, rd);
    check_value("prdata members", rd, 32'd0);

    apply_cfg(1, 0, 0);
    send_burst(30);
    wait_idle();
    apply_cfg(1, 1, 0);
    send_burst(30);
    wait_idle();
    apply_cfg(2, 1, 0);
    send_burst(30);
    wait_idle();

    write_reg(ADDR_STRIDE, 32'd0, 1'b1);  // Kernel 5 stride 1, group of 5
    read_reg(ADDR_STRIDE, rd);
    check_value("prdata stride", rd, 32'd1);

    apply_cfg(1, 0, 1);
    send_burst(30);
    apply_cfg(2, 1, 2); // Earlier beats still draining
    send_burst(30);
    wait_idle();
    apply_cfg(1, 1, 3);
    send_burst(50);
    wait_idle();

    // Nothing left in the pipeline once the model is empty
    repeat (QUIET_CYCLES) begin
      @(posedge aclk);
      #1;
    end
    check_value("m_valid", m_valid, 1'b0);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
dw_pkg.sv
dw_stream_if.sv
dw_cfg_regs.sv
dw_column_shifter.sv
dw_column_select.sv
skid_buffer.sv
dw_shift_top.sv
dw_shift_checker.sv
tb_dw_shift.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_dw_shift -f sim.f -o sim_dw_shift
./obj_dir/sim_dw_shift > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
  exit 1
fi
exit 0
